/* Makefile */
VERILATOR ?= verilator
TOP       ?= trdb_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the testbench prints its pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

/* hw/trdb_branch_map.sv */
// branch map of the current run
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module trdb_branch_map (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire logic                      branch_i,
    input  wire logic                      taken_i,
    input  wire logic                      flush_i,
    output logic [`TRDB_BCNT_W-1:0]        count_o,
    output logic [`TRDB_BMAP_MAX-1:0]      map_o,
    output logic                           empty_o,
    output logic                           full_o
);

    localparam logic [`TRDB_BCNT_W-1:0] BMAP_MAX = `TRDB_BCNT_W'(`TRDB_BMAP_MAX);

    logic [`TRDB_BCNT_W-1:0]   count_q;
    logic [`TRDB_BMAP_MAX-1:0] map_q;
    // run start after an optional flush
    logic [`TRDB_BCNT_W-1:0]   base_count;
    logic [`TRDB_BMAP_MAX-1:0] base_map;
    logic [`TRDB_BCNT_W-1:0]   count_d;
    logic [`TRDB_BMAP_MAX-1:0] map_d;

    // packet has already sampled the old run when flush is high
    assign base_count = flush_i ? '0 : count_q;
    assign base_map   = flush_i ? '0 : map_q;

    always_comb begin
        count_d = base_count;
        map_d   = base_map;
        if (branch_i) begin
            // tc branch opens the new run after a flush
            map_d   = base_map | (`TRDB_BMAP_MAX'(taken_i) << base_count);
            count_d = base_count + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            map_q <= '0;
        end else begin
            map_q <= map_d;
        end
    end

    assign count_o = count_q;
    assign map_o   = map_q;
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == BMAP_MAX);

    // relies on priority flushing a full map before the next branch
    a_count_bound: assert property (@(posedge clk_i) disable iff (reset_i)
        branch_i && !flush_i |-> count_q < BMAP_MAX);

endmodule

`default_nettype wire

/* hw/trdb_instr_pkg.sv */
// retirement side types
`default_nettype none

`include "trdb_macros.svh"

package trdb_instr_pkg;

    // one retired instruction as seen by the encoder
    typedef struct packed {
        logic                     valid;
        logic                     qualified;
        logic [`TRDB_XLEN-1:0]    iaddr;
        logic                     is_branch;
        logic                     taken;
        logic                     exception;
        logic [`TRDB_CAUSE_W-1:0] cause;
        logic [`TRDB_XLEN-1:0]    tval;
        logic [1:0]               priv;
        // software context id
        logic [`TRDB_CTX_W-1:0]   ctx;
        // uninferable pc discontinuity
        logic                     updiscon;
    } trdb_retire_s;

    // per-stage change flags for the priority block
    typedef struct packed {
        logic lc_exception;
        logic lc_updiscon;
        logic tc_qualified;
        logic tc_is_branch;
        logic tc_exception;
        logic tc_first_qualified;
        logic tc_privchange;
        logic tc_context_change;
        // resync timer expired
        logic tc_resync;
        logic nc_exception;
        logic nc_privchange;
        logic nc_qualified;
    } trdb_flags_s;

endpackage

`default_nettype wire

/* hw/trdb_macros.svh */
// trace encoder widths and limits
`ifndef TRDB_MACROS_SVH
`define TRDB_MACROS_SVH

// address and trap value width
`define TRDB_XLEN 32
// branch map capacity in branches
`define TRDB_BMAP_MAX 31
// width of the branch count field
`define TRDB_BCNT_W $clog2(`TRDB_BMAP_MAX + 1)
// qualified retirements between forced sync packets
`define TRDB_RESYNC_MAX 64
`define TRDB_CAUSE_W 5
`define TRDB_CTX_W 4
// payload word shared by sync and branch layouts
`define TRDB_PAYLOAD_W 102

`endif

/* hw/trdb_packet_emitter.sv */
// packet assembly and output register
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module trdb_packet_emitter (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire logic                      emit_i,
    input  trdb_pkg::trdb_format_e         format_i,
    input  trdb_pkg::trdb_subformat_e      subformat_i,
    input  wire logic                      thaddr_i,
    input  trdb_instr_pkg::trdb_retire_s   tc_rec_i,
    input  trdb_instr_pkg::trdb_retire_s   lc_rec_i,
    input  wire logic [`TRDB_BCNT_W-1:0]   bmap_count_i,
    input  wire logic [`TRDB_BMAP_MAX-1:0] bmap_map_i,
    output logic                           packet_valid_o,
    output trdb_pkg::trdb_packet_s         packet_o
);

    import trdb_pkg::*;

    trdb_payload_u payload;
    trdb_packet_s  packet_d;
    logic          packet_valid_q;
    trdb_packet_s  packet_q;

    always_comb begin
        payload = '0;
        if (format_i == F3) begin
            payload.sync.priv    = tc_rec_i.priv;
            payload.sync.ctx     = tc_rec_i.ctx;
            payload.sync.address = tc_rec_i.iaddr;
            if (subformat_i == SF_EXC) begin
                payload.sync.thaddr = thaddr_i;
                // thaddr set means lc took the trap
                payload.sync.cause  = thaddr_i ? lc_rec_i.cause : tc_rec_i.cause;
                payload.sync.tval   = thaddr_i ? lc_rec_i.tval : tc_rec_i.tval;
            end
        end else begin
            payload.branch.branches   = bmap_count_i;
            payload.branch.branch_map = bmap_map_i;
            // f0 carries no address
            if (format_i != F0) begin
                payload.branch.address = tc_rec_i.iaddr;
            end
        end
    end

    always_comb begin
        packet_d.format    = format_i;
        packet_d.subformat = subformat_i;
        packet_d.payload   = payload;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            packet_valid_q <= 1'b0;
        end else begin
            packet_valid_q <= emit_i;
        end
    end

    // hold the last packet between emits
    always_ff @(posedge clk_i) begin
        if (emit_i) begin
            packet_q <= packet_d;
        end
    end

    assign packet_valid_o = packet_valid_q;
    assign packet_o       = packet_q;

    // f0 is only chosen with a full map
    a_f0_full: assert property (@(posedge clk_i) disable iff (reset_i)
        emit_i && (format_i == F0) |-> bmap_count_i == `TRDB_BCNT_W'(`TRDB_BMAP_MAX));

endmodule

`default_nettype wire

/* hw/trdb_pkg.sv */
// packet side types
`default_nettype none

`include "trdb_macros.svh"

package trdb_pkg;

    // packet format where f3 carries a subformat
    typedef enum logic [1:0] {
        F0 = 2'd0,
        F1 = 2'd1,
        F2 = 2'd2,
        F3 = 2'd3
    } trdb_format_e;

    typedef enum logic [1:0] {
        SF_SYNC = 2'd0,
        SF_EXC  = 2'd1,
        SF_CTX  = 2'd2
    } trdb_subformat_e;

    // f3 layout with the address in the low bits like the branch layout
    typedef struct packed {
        logic [`TRDB_PAYLOAD_W-2-`TRDB_CTX_W-1-`TRDB_CAUSE_W-2*`TRDB_XLEN-1:0] pad;
        logic [1:0]                                      priv;
        logic [`TRDB_CTX_W-1:0]                          ctx;
        // set when address is the trap handler
        logic                                            thaddr;
        logic [`TRDB_CAUSE_W-1:0]                        cause;
        logic [`TRDB_XLEN-1:0]                           tval;
        logic [`TRDB_XLEN-1:0]                           address;
    } trdb_sync_s;

    // f0, f1 and f2 layout
    typedef struct packed {
        logic [`TRDB_BCNT_W-1:0]                         branches;
        logic [`TRDB_BMAP_MAX-1:0]                       branch_map;
        logic [`TRDB_PAYLOAD_W-`TRDB_BCNT_W-`TRDB_BMAP_MAX-`TRDB_XLEN-1:0] pad;
        logic [`TRDB_XLEN-1:0]                           address;
    } trdb_branch_s;

    // one payload word, decoded by format
    typedef union packed {
        trdb_sync_s   sync;
        trdb_branch_s branch;
    } trdb_payload_u;

    typedef struct packed {
        trdb_format_e    format;
        trdb_subformat_e subformat;
        trdb_payload_u   payload;
    } trdb_packet_s;

endpackage

`default_nettype wire

/* hw/trdb_priority.sv */
// packet format selection
`timescale 1ns/1ps
`default_nettype none

module trdb_priority (
    input  trdb_instr_pkg::trdb_flags_s  flags_i,
    input  wire logic                    bmap_empty_i,
    input  wire logic                    bmap_full_i,
    output logic                         emit_o,
    output trdb_pkg::trdb_format_e       format_o,
    output trdb_pkg::trdb_subformat_e    subformat_o,
    output logic                         thaddr_o,
    output logic                         flush_o
);

    import trdb_pkg::*;

    // exception or priv change on the next instruction
    logic nc_event;
    // first trace, priv change or timer expiry
    logic sync_event;

    assign nc_event   = flags_i.nc_qualified &
                        (flags_i.nc_exception | flags_i.nc_privchange);
    assign sync_event = flags_i.tc_first_qualified |
                        flags_i.tc_privchange |
                        flags_i.tc_resync;

    // first matching rule wins
    always_comb begin
        emit_o      = 1'b0;
        format_o    = F0;
        subformat_o = SF_SYNC;
        thaddr_o    = 1'b0;
        flush_o     = 1'b0;

        // nothing is traced for unqualified tc
        if (flags_i.tc_qualified) begin
            if (flags_i.lc_exception) begin
                // tc is the first handler instruction
                emit_o      = 1'b1;
                format_o    = F3;
                subformat_o = SF_EXC;
                thaddr_o    = 1'b1;
                flush_o     = 1'b1;
            end else if (sync_event) begin
                emit_o      = 1'b1;
                format_o    = F3;
                subformat_o = SF_SYNC;
                flush_o     = 1'b1;
            end else if (flags_i.lc_updiscon && flags_i.tc_exception) begin
                // jump target itself traps
                emit_o      = 1'b1;
                format_o    = F3;
                subformat_o = SF_EXC;
                thaddr_o    = 1'b0;
                flush_o     = 1'b1;
            end else if (flags_i.lc_updiscon || nc_event) begin
                // address packet with any branches riding along
                emit_o      = 1'b1;
                format_o    = bmap_empty_i ? F2 : F1;
                flush_o     = 1'b1;
            end else if (bmap_full_i) begin
                // map only without an address
                emit_o      = 1'b1;
                format_o    = F0;
                flush_o     = 1'b1;
            end else if (flags_i.tc_context_change) begin
                // context only so the branch run continues
                emit_o      = 1'b1;
                format_o    = F3;
                subformat_o = SF_CTX;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/trdb_top.sv */
// trace encoder top
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module trdb_top (
    input  wire logic                     clk_i,
    input  wire logic                     reset_i,
    input  trdb_instr_pkg::trdb_retire_s  retire_i,
    output logic                          packet_valid_o,
    output trdb_pkg::trdb_packet_s        packet_o
);

    import trdb_instr_pkg::*;
    import trdb_pkg::*;

    trdb_flags_s               flags;
    trdb_retire_s              tc_rec;
    trdb_retire_s              lc_rec;
    logic                      branch;
    logic                      taken;
    logic [`TRDB_BCNT_W-1:0]   bmap_count;
    logic [`TRDB_BMAP_MAX-1:0] bmap_map;
    logic                      bmap_empty;
    logic                      bmap_full;
    logic                      emit;
    trdb_format_e              format;
    trdb_subformat_e           subformat;
    logic                      thaddr;
    logic                      flush;

    trdb_window u_window (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .retire_i (retire_i),
        .flags_o  (flags),
        .tc_rec_o (tc_rec),
        .lc_rec_o (lc_rec),
        .branch_o (branch),
        .taken_o  (taken)
    );

    trdb_branch_map u_branch_map (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .branch_i(branch),
        .taken_i (taken),
        .flush_i (flush),
        .count_o (bmap_count),
        .map_o   (bmap_map),
        .empty_o (bmap_empty),
        .full_o  (bmap_full)
    );

    trdb_priority u_priority (
        .flags_i     (flags),
        .bmap_empty_i(bmap_empty),
        .bmap_full_i (bmap_full),
        .emit_o      (emit),
        .format_o    (format),
        .subformat_o (subformat),
        .thaddr_o    (thaddr),
        .flush_o     (flush)
    );

    trdb_packet_emitter u_emitter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .emit_i        (emit),
        .format_i      (format),
        .subformat_i   (subformat),
        .thaddr_i      (thaddr),
        .tc_rec_i      (tc_rec),
        .lc_rec_i      (lc_rec),
        .bmap_count_i  (bmap_count),
        .bmap_map_i    (bmap_map),
        .packet_valid_o(packet_valid_o),
        .packet_o      (packet_o)
    );

    // a flush rides on a packet and leaves at most the tc branch
    a_flush_emit: assert property (@(posedge clk_i) disable iff (reset_i)
        flush |-> emit ##1 (bmap_count <= `TRDB_BCNT_W'(1)));

endmodule

`default_nettype wire

/* hw/trdb_window.sv */
// retirement window and change flags
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module trdb_window (
    input  wire logic                       clk_i,
    input  wire logic                       reset_i,
    input  trdb_instr_pkg::trdb_retire_s    retire_i,
    output trdb_instr_pkg::trdb_flags_s     flags_o,
    output trdb_instr_pkg::trdb_retire_s    tc_rec_o,
    output trdb_instr_pkg::trdb_retire_s    lc_rec_o,
    output logic                            branch_o,
    output logic                            taken_o
);

    import trdb_instr_pkg::*;

    localparam int RESYNC_W = $clog2(`TRDB_RESYNC_MAX + 1);

    trdb_retire_s in_d;
    // sample stage followed by next, this and last cycle
    trdb_retire_s in_q;
    trdb_retire_s nc_q;
    trdb_retire_s tc_q;
    trdb_retire_s lc_q;
    trdb_flags_s  flags;

    // any qualified retirement seen since reset
    logic                   seen_q;
    // priv and context of the last qualified record
    logic [1:0]             last_priv_q;
    logic [`TRDB_CTX_W-1:0] last_ctx_q;
    logic [RESYNC_W-1:0]    resync_cnt_q;

    // reference for nc comparisons where a qualified tc wins
    logic                   ref_valid;
    logic [1:0]             ref_priv;

    // empty cycles shift in an all-zero record
    always_comb begin
        in_d = retire_i;
        if (!retire_i.valid) begin
            in_d = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            in_q <= '0;
            nc_q <= '0;
            tc_q <= '0;
            lc_q <= '0;
        end else begin
            in_q <= in_d;
            nc_q <= in_q;
            tc_q <= nc_q;
            lc_q <= tc_q;
        end
    end

    // history of the last qualified retirement
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            seen_q <= 1'b0;
        end else if (tc_q.qualified) begin
            seen_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (tc_q.qualified) begin
            last_priv_q <= tc_q.priv;
            last_ctx_q  <= tc_q.ctx;
        end
    end

    // counts qualified tc retirements and wraps on resync
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resync_cnt_q <= '0;
        end else if (flags.tc_resync) begin
            resync_cnt_q <= '0;
        end else if (tc_q.qualified) begin
            resync_cnt_q <= resync_cnt_q + 1'b1;
        end
    end

    assign ref_valid = tc_q.qualified | seen_q;
    assign ref_priv  = tc_q.qualified ? tc_q.priv : last_priv_q;

    always_comb begin
        flags = '0;
        flags.lc_exception       = lc_q.qualified & lc_q.exception;
        flags.lc_updiscon        = lc_q.qualified & lc_q.updiscon;
        flags.tc_qualified       = tc_q.qualified;
        flags.tc_is_branch       = tc_q.qualified & tc_q.is_branch;
        flags.tc_exception       = tc_q.qualified & tc_q.exception;
        flags.tc_first_qualified = tc_q.qualified & ~seen_q;
        // changes only count once something qualified was traced
        flags.tc_privchange      = tc_q.qualified & seen_q & (tc_q.priv != last_priv_q);
        flags.tc_context_change  = tc_q.qualified & seen_q & (tc_q.ctx != last_ctx_q);
        flags.tc_resync          = tc_q.qualified &
                                   (resync_cnt_q == RESYNC_W'(`TRDB_RESYNC_MAX - 1));
        // nc flags stay raw since priority gates them with nc_qualified
        flags.nc_exception       = nc_q.exception;
        flags.nc_privchange      = ref_valid & (nc_q.priv != ref_priv);
        flags.nc_qualified       = nc_q.qualified;
    end

    assign flags_o  = flags;
    assign tc_rec_o = tc_q;
    assign lc_rec_o = lc_q;
    // only qualified branches reach the map
    assign branch_o = flags.tc_is_branch;
    assign taken_o  = tc_q.taken;

    // nothing was counted before the first qualified retirement
    a_first_qual: assert property (@(posedge clk_i) disable iff (reset_i)
        flags.tc_first_qualified |-> flags.tc_qualified && resync_cnt_q == '0);

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/trdb_instr_pkg.sv
hw/trdb_pkg.sv
hw/trdb_window.sv
hw/trdb_branch_map.sv
hw/trdb_priority.sv
hw/trdb_packet_emitter.sv
hw/trdb_top.sv
verification/trdb_tb.sv

/* verification/trdb_tb.sv */
// trace encoder testbench
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module trdb_tb;

    import trdb_instr_pkg::*;
    import trdb_pkg::*;

    localparam int N_ROWS      = 8;
    localparam int MAX_REC     = N_ROWS * 40;
    localparam int CYCLE_LIMIT = N_ROWS * 45 + 100;

    // kinds of generated retirement
    localparam int K_PLAIN  = 0;
    localparam int K_BRANCH = 1;
    localparam int K_JUMP   = 2;
    localparam int K_EXC    = 3;
    localparam int K_PRIV   = 4;
    localparam int K_CTX    = 5;
    localparam int K_UNQUAL = 6;
    localparam int K_IDLE   = 7;

    // row stimulus patterns
    localparam int P_FIRST   = 0;
    localparam int P_EXC     = 1;
    localparam int P_JUMP_BR = 2;
    localparam int P_JUMP    = 3;
    localparam int P_FULL    = 4;
    localparam int P_PRIVCTX = 5;
    localparam int P_IDLE    = 6;
    localparam int P_RESYNC  = 7;

    // test table of name, pattern, length and the packet kind each row must produce
    string           row_name    [N_ROWS] = '{"first_sync", "exception", "jump_branches",
                                              "jump_no_branch", "bmap_full", "priv_ctx",
                                              "unqualified_idle", "resync_timer"};
    int              row_pat     [N_ROWS] = '{P_FIRST, P_EXC, P_JUMP_BR, P_JUMP, P_FULL,
                                              P_PRIVCTX, P_IDLE, P_RESYNC};
    int              row_len     [N_ROWS] = '{6, 6, 10, 5, 36, 10, 40, 40};
    bit              row_has_key [N_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    trdb_format_e    row_key_fmt [N_ROWS] = '{F3, F3, F1, F2, F0, F3, F0, F3};
    trdb_subformat_e row_key_sf  [N_ROWS] = '{SF_SYNC, SF_EXC, SF_SYNC, SF_SYNC, SF_SYNC,
                                              SF_CTX, SF_SYNC, SF_SYNC};

    logic         clk_i = 1'b0;
    logic         reset_i;
    trdb_retire_s retire_i;
    logic         packet_valid_o;
    trdb_packet_s packet_o;

    // whole stimulus stream and its expected packets with one entry per cycle
    trdb_retire_s stream     [MAX_REC];
    int           stream_row [MAX_REC];
    logic         exp_valid  [MAX_REC];
    trdb_packet_s exp_pkt    [MAX_REC];
    int           row_hits   [N_ROWS];
    int           n_rec;
    int           errors;
    int           checks;
    int           cycles = 0;

    // generator state
    logic [`TRDB_XLEN-1:0]  pc;
    logic [1:0]             cur_priv;
    logic [`TRDB_CTX_W-1:0] cur_ctx;

    trdb_top UUT (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .retire_i      (retire_i),
        .packet_valid_o(packet_valid_o),
        .packet_o      (packet_o)
    );

    always #5 clk_i = ~clk_i;

    // run limit scales with the table
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic int pick_kind(input int pat, input int i, input int len);
        int kind;
        kind = K_PLAIN;
        case (pat)
            P_FIRST:   kind = (i < 2) ? K_IDLE : K_PLAIN;
            P_EXC:     kind = (i == 2) ? K_EXC : K_PLAIN;
            P_JUMP_BR: kind = (i < 6) ? K_BRANCH : ((i == 7) ? K_JUMP : K_PLAIN);
            P_JUMP:    kind = (i == 1) ? K_JUMP : K_PLAIN;
            // the 32nd branch finds the map full
            P_FULL:    kind = (i < len - 1) ? K_BRANCH : K_PLAIN;
            P_PRIVCTX: begin
                case (i)
                    2:       kind = K_PRIV;
                    3:       kind = K_BRANCH;
                    5:       kind = K_CTX;
                    7:       kind = K_JUMP;
                    default: kind = K_PLAIN;
                endcase
            end
            P_IDLE:    kind = (i % 5 == 4) ? K_IDLE : ((i % 7 == 3) ? K_UNQUAL : K_PLAIN);
            default:   kind = K_PLAIN;
        endcase
        return kind;
    endfunction

    task automatic push_rec(input int row, input int kind);
        trdb_retire_s r;
        logic [31:0]  rnd;
        rnd = $urandom;
        r   = '0;
        if (kind == K_PRIV) begin
            cur_priv = 2'd1;
        end
        if (kind == K_CTX) begin
            cur_ctx = cur_ctx + 1'b1;
        end
        r.valid     = (kind != K_IDLE);
        r.qualified = (kind != K_UNQUAL);
        r.iaddr     = (kind == K_IDLE) ? rnd : pc;
        r.is_branch = (kind == K_BRANCH);
        r.taken     = rnd[0];
        r.exception = (kind == K_EXC);
        r.cause     = rnd[8:4];
        r.tval      = ~rnd;
        r.priv      = cur_priv;
        r.ctx       = cur_ctx;
        r.updiscon  = (kind == K_JUMP);
        // idle cycles carry junk that must be ignored
        if (kind == K_IDLE) begin
            r.priv      = rnd[2:1];
            r.exception = rnd[3];
            r.updiscon  = rnd[5];
            r.is_branch = rnd[6];
        end
        // unqualified records trap and jump yet stay untraced
        if (kind == K_UNQUAL) begin
            r.exception = 1'b1;
            r.updiscon  = 1'b1;
        end
        if (kind == K_JUMP) begin
            pc = 32'h0001_0000 | (rnd & 32'h0000_fffc);
        end else if (kind == K_EXC) begin
            // trap vector
            pc = 32'h0000_0200;
        end else if (kind != K_IDLE) begin
            pc = pc + 32'd4;
        end
        stream[n_rec]     = r;
        stream_row[n_rec] = row;
        n_rec++;
    endtask

    // record as the encoder sees it and empty outside the stream
    function automatic trdb_retire_s clean_rec(input int idx);
        trdb_retire_s r;
        r = '0;
        if (idx >= 0 && idx < n_rec && stream[idx].valid) begin
            r = stream[idx];
        end
        return r;
    endfunction

    // expected packet for every record while it is tc
    task automatic model_packets();
        trdb_retire_s              tc;
        trdb_retire_s              lc;
        trdb_retire_s              nc;
        trdb_packet_s              pkt;
        trdb_format_e              fmt;
        trdb_subformat_e           sf;
        logic                      seen;
        logic [1:0]                last_priv;
        logic [`TRDB_CTX_W-1:0]    last_ctx;
        int                        resync_cnt;
        logic [`TRDB_BCNT_W-1:0]   bcount;
        logic [`TRDB_BMAP_MAX-1:0] bmap;
        logic                      emit;
        logic                      flush;
        logic                      thaddr;
        logic                      resync;
        logic                      nc_event;
        seen       = 1'b0;
        last_priv  = '0;
        last_ctx   = '0;
        resync_cnt = 0;
        bcount     = '0;
        bmap       = '0;
        for (int t = 0; t < n_rec; t++) begin
            tc     = clean_rec(t);
            lc     = clean_rec(t - 1);
            nc     = clean_rec(t + 1);
            emit   = 1'b0;
            flush  = 1'b0;
            thaddr = 1'b0;
            resync = 1'b0;
            fmt    = F0;
            sf     = SF_SYNC;
            if (tc.qualified) begin
                resync   = (resync_cnt == `TRDB_RESYNC_MAX - 1);
                nc_event = nc.qualified & (nc.exception | (nc.priv != tc.priv));
                emit     = 1'b1;
                flush    = 1'b1;
                if (lc.qualified && lc.exception) begin
                    fmt    = F3;
                    sf     = SF_EXC;
                    thaddr = 1'b1;
                end else if (!seen || tc.priv != last_priv || resync) begin
                    fmt = F3;
                end else if (lc.qualified && lc.updiscon && tc.exception) begin
                    fmt = F3;
                    sf  = SF_EXC;
                end else if ((lc.qualified && lc.updiscon) || nc_event) begin
                    fmt = (bcount == '0) ? F2 : F1;
                end else if (bcount == `TRDB_BCNT_W'(`TRDB_BMAP_MAX)) begin
                    fmt = F0;
                end else if (tc.ctx != last_ctx) begin
                    // branch run keeps going
                    fmt   = F3;
                    sf    = SF_CTX;
                    flush = 1'b0;
                end else begin
                    emit  = 1'b0;
                    flush = 1'b0;
                end
            end
            pkt           = '0;
            pkt.format    = fmt;
            pkt.subformat = sf;
            if (fmt == F3) begin
                pkt.payload.sync.priv    = tc.priv;
                pkt.payload.sync.ctx     = tc.ctx;
                pkt.payload.sync.address = tc.iaddr;
                if (sf == SF_EXC) begin
                    pkt.payload.sync.thaddr = thaddr;
                    pkt.payload.sync.cause  = thaddr ? lc.cause : tc.cause;
                    pkt.payload.sync.tval   = thaddr ? lc.tval : tc.tval;
                end
            end else begin
                pkt.payload.branch.branches   = bcount;
                pkt.payload.branch.branch_map = bmap;
                if (fmt != F0) begin
                    pkt.payload.branch.address = tc.iaddr;
                end
            end
            exp_valid[t] = emit;
            exp_pkt[t]   = pkt;
            // the packet took the old run and the tc branch opens the next one
            if (flush) begin
                bcount = '0;
                bmap   = '0;
            end
            if (tc.qualified && tc.is_branch) begin
                bmap[bcount] = tc.taken;
                bcount       = bcount + 1'b1;
            end
            if (tc.qualified) begin
                seen       = 1'b1;
                last_priv  = tc.priv;
                last_ctx   = tc.ctx;
                resync_cnt = resync ? 0 : resync_cnt + 1;
            end
        end
    endtask

    task automatic check_packet(input string name, input trdb_packet_s exp,
                                input trdb_packet_s act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s at %0t: packet expected %h actual %h", name, $time, exp, act);
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s at %0t: valid expected %b actual %b", name, $time, exp, act);
        end
    endtask

    initial begin
        int    seed;
        int    idx;
        int    row;
        reset_i  = 1'b1;
        retire_i = '0;
        errors   = 0;
        checks   = 0;
        n_rec    = 0;
        pc       = 32'h0000_1000;
        cur_priv = 2'd3;
        cur_ctx  = `TRDB_CTX_W'(1);
        seed     = $urandom(32'hb9c2);
        // build the stream row by row and then predict it
        for (int r = 0; r < N_ROWS; r++) begin
            row_hits[r] = 0;
            for (int i = 0; i < row_len[r]; i++) begin
                push_rec(r, pick_kind(row_pat[r], i, row_len[r]));
            end
        end
        model_packets();
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        // packet for record c shows up after the fourth edge from its drive edge
        for (int c = 0; c < n_rec + 6; c++) begin
            @(posedge clk_i);
            if (c < n_rec) begin
                retire_i <= stream[c];
            end else begin
                retire_i <= '0;
            end
            @(negedge clk_i);
            idx = c - 4;
            if (idx >= 0 && idx < n_rec) begin
                row = stream_row[idx];
                check_valid(row_name[row], exp_valid[idx], packet_valid_o);
                if (exp_valid[idx] && packet_valid_o) begin
                    check_packet(row_name[row], exp_pkt[idx], packet_o);
                end
                if (packet_valid_o && packet_o.format == row_key_fmt[row] &&
                    (row_key_fmt[row] != F3 || packet_o.subformat == row_key_sf[row])) begin
                    row_hits[row]++;
                end
            end else begin
                check_valid("idle", 1'b0, packet_valid_o);
            end
        end
        for (int r = 0; r < N_ROWS; r++) begin
            if (row_has_key[r] && row_hits[r] == 0) begin
                errors++;
                $display("row %s never produced the packet kind it is meant to", row_name[r]);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
